//--- logic/aes_pkg.sv
package aes_pkg;

    localparam int NUM_ROUNDS    = 10;
    localparam int NUM_KEY_WORDS = 4;

    // one state, flat for key addition or as sixteen bytes, byte 0 on top
    typedef union packed {
        logic [127:0]       word;
        logic [0:15][7:0]   bytes;
    } aes_block_u;

    typedef logic [127:0] aes_key_t;
    typedef logic [3:0]   round_idx_t;

    typedef struct packed {
        logic       decrypt;
        aes_block_u data;
    } aes_req_t;

    localparam logic [0:255][7:0] SBOX = {
        128'h637c777bf26b6fc53001672bfed7ab76, 128'hca82c97dfa5947f0add4a2af9ca472c0,
        128'hb7fd9326363ff7cc34a5e5f171d83115, 128'h04c723c31896059a071280e2eb27b275,
        128'h09832c1a1b6e5aa0523bd6b329e32f84, 128'h53d100ed20fcb15b6acbbe394a4c58cf,
        128'hd0efaafb434d338545f9027f503c9fa8, 128'h51a3408f929d38f5bcb6da2110fff3d2,
        128'hcd0c13ec5f974417c4a77e3d645d1973, 128'h60814fdc222a908846eeb814de5e0bdb,
        128'he0323a0a4906245cc2d3ac629195e479, 128'he7c8376d8dd54ea96c56f4ea657aae08,
        128'hba78252e1ca6b4c6e8dd741f4bbd8b8a, 128'h703eb5664803f60e613557b986c11d9e,
        128'he1f8981169d98e949b1e87e9ce5528df, 128'h8ca1890dbfe6426841992d0fb054bb16
    };

    localparam logic [0:255][7:0] INV_SBOX = {
        128'h52096ad53036a538bf40a39e81f3d7fb, 128'h7ce339829b2fff87348e4344c4dee9cb,
        128'h547b9432a6c2233dee4c950b42fac34e, 128'h082ea16628d924b2765ba2496d8bd125,
        128'h72f8f66486689816d4a45ccc5d65b692, 128'h6c704850fdedb9da5e154657a78d9d84,
        128'h90d8ab008cbcd30af7e45805b8b34506, 128'hd02c1e8fca3f0f02c1afbd0301138a6b,
        128'h3a9111414f67dcea97f2cfcef0b4e673, 128'h96ac7422e7ad3585e2f937e81c75df6e,
        128'h47f11a711d29c5896fb7620eaa18be1b, 128'hfc563e4bc6d279209adbc0fe78cd5af4,
        128'h1fdda8338807c731b11210592780ec5f, 128'h60517fa919b54a0d2de57a9f93c99cef,
        128'ha0e03b4dae2af5b0c8ebbb3c83539961, 128'h172b047eba77d626e169146355210c7d
    };

    // rcon for rounds 1 to 10
    localparam logic [0:NUM_ROUNDS-1][7:0] RCON = 80'h01020408102040801b36;

    function automatic logic [7:0] mul2(input logic [7:0] b);
        return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
    endfunction

    function automatic aes_block_u sub_bytes(input aes_block_u s);
        aes_block_u o;
        for (int i = 0; i < 16; i++) begin
            o.bytes[i] = SBOX[s.bytes[i]];
        end
        return o;
    endfunction

    function automatic aes_block_u inv_sub_bytes(input aes_block_u s);
        aes_block_u o;
        for (int i = 0; i < 16; i++) begin
            o.bytes[i] = INV_SBOX[s.bytes[i]];
        end
        return o;
    endfunction

    // row r rotates left by r columns
    function automatic aes_block_u shift_rows(input aes_block_u s);
        aes_block_u o;
        for (int c = 0; c < 4; c++) begin
            for (int r = 0; r < 4; r++) begin
                o.bytes[4*c + r] = s.bytes[4*((c + r) % 4) + r];
            end
        end
        return o;
    endfunction

    function automatic aes_block_u inv_shift_rows(input aes_block_u s);
        aes_block_u o;
        for (int c = 0; c < 4; c++) begin
            for (int r = 0; r < 4; r++) begin
                o.bytes[4*c + r] = s.bytes[4*((c + 4 - r) % 4) + r];
            end
        end
        return o;
    endfunction

    function automatic aes_block_u mix_columns(input aes_block_u s);
        aes_block_u o;
        logic [7:0] a0, a1, a2, a3;
        for (int c = 0; c < 4; c++) begin
            a0 = s.bytes[4*c];
            a1 = s.bytes[4*c + 1];
            a2 = s.bytes[4*c + 2];
            a3 = s.bytes[4*c + 3];
            o.bytes[4*c]     = mul2(a0) ^ mul2(a1) ^ a1 ^ a2 ^ a3;
            o.bytes[4*c + 1] = a0 ^ mul2(a1) ^ mul2(a2) ^ a2 ^ a3;
            o.bytes[4*c + 2] = a0 ^ a1 ^ mul2(a2) ^ mul2(a3) ^ a3;
            o.bytes[4*c + 3] = mul2(a0) ^ a0 ^ a1 ^ a2 ^ mul2(a3);
        end
        return o;
    endfunction

    // inverse matrix factors into a cheap 5/4 pre-step followed by the forward one
    function automatic aes_block_u inv_mix_columns(input aes_block_u s);
        aes_block_u p;
        logic [7:0] u, v;
        p = s;
        for (int c = 0; c < 4; c++) begin
            u = mul2(mul2(s.bytes[4*c] ^ s.bytes[4*c + 2]));
            v = mul2(mul2(s.bytes[4*c + 1] ^ s.bytes[4*c + 3]));
            p.bytes[4*c]     = s.bytes[4*c] ^ u;
            p.bytes[4*c + 1] = s.bytes[4*c + 1] ^ v;
            p.bytes[4*c + 2] = s.bytes[4*c + 2] ^ u;
            p.bytes[4*c + 3] = s.bytes[4*c + 3] ^ v;
        end
        return mix_columns(p);
    endfunction

    function automatic logic [31:0] sub_word(input logic [31:0] w);
        return {SBOX[w[31:24]], SBOX[w[23:16]], SBOX[w[15:8]], SBOX[w[7:0]]};
    endfunction

    function automatic logic [31:0] rot_word(input logic [31:0] w);
        return {w[23:0], w[31:24]};
    endfunction

endpackage

//--- logic/aes_key_schedule.sv
`timescale 1ns/1ps

module aes_key_schedule
    import aes_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       key_load,
    input  aes_key_t   key,
    input  logic       busy,
    input  round_idx_t round_idx,
    output aes_block_u round_key,
    output logic       key_ready
);

    aes_block_u rk_q [0:NUM_ROUNDS];
    aes_block_u next_key;
    round_idx_t kcnt_q;
    logic       expanding_q;
    logic       load_ok;
    logic [31:0] temp;

    // no new key while a block is in flight
    assign load_ok = key_load && !busy;

    // kcnt_q stays within 1..10, so both lookups are in range
    always_comb begin
        temp = sub_word(rot_word(rk_q[kcnt_q - 4'd1].word[31:0]))
             ^ {RCON[kcnt_q - 4'd1], 24'h000000};
        for (int j = 0; j < NUM_KEY_WORDS; j++) begin
            temp = rk_q[kcnt_q - 4'd1].word[127 - 32*j -: 32] ^ temp;
            next_key.word[127 - 32*j -: 32] = temp;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            kcnt_q      <= 4'd1;
            expanding_q <= 1'b0;
            key_ready   <= 1'b0;
        end else if (load_ok) begin
            kcnt_q      <= 4'd1;
            expanding_q <= 1'b1;
            key_ready   <= 1'b0;
        end else if (expanding_q) begin
            if (kcnt_q == round_idx_t'(NUM_ROUNDS)) begin
                expanding_q <= 1'b0;
                key_ready   <= 1'b1;
            end else begin
                kcnt_q <= kcnt_q + 4'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load_ok) begin
            rk_q[0].word <= key;
        end else if (expanding_q) begin
            rk_q[kcnt_q] <= next_key;
        end
    end

    assign round_key = rk_q[round_idx];

    // full expansion takes ten edges before the key can be used
    a_ready_latency: assert property (@(posedge clk) disable iff (reset)
        load_ok |=> !key_ready [*10]);

endmodule

//--- logic/aes_round.sv
`timescale 1ns/1ps

module aes_round
    import aes_pkg::*;
(
    input  aes_block_u state,
    input  aes_block_u round_key,
    input  logic       decrypt,
    input  logic       last_round,
    output aes_block_u next_state
);

    aes_block_u fwd_sub;
    aes_block_u fwd_shift;
    aes_block_u fwd_mix;
    aes_block_u inv_shift;
    aes_block_u inv_sub;
    aes_block_u inv_key;

    // forward round
    always_comb begin
        fwd_sub   = sub_bytes(state);
        fwd_shift = shift_rows(fwd_sub);
        if (last_round) begin
            fwd_mix = fwd_shift;
        end else begin
            fwd_mix = mix_columns(fwd_shift);
        end
    end

    // inverse round, key added before the column step
    always_comb begin
        inv_shift    = inv_shift_rows(state);
        inv_sub      = inv_sub_bytes(inv_shift);
        inv_key.word = inv_sub.word ^ round_key.word;
    end

    always_comb begin
        if (decrypt) begin
            if (last_round) begin
                next_state = inv_key;
            end else begin
                next_state = inv_mix_columns(inv_key);
            end
        end else begin
            next_state.word = fwd_mix.word ^ round_key.word;
        end
    end

endmodule

//--- logic/aes_core.sv
`timescale 1ns/1ps

module aes_core
    import aes_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  aes_req_t   req,
    input  logic       start,
    input  logic       key_ready,
    input  aes_block_u round_key,
    input  aes_block_u next_state,
    output round_idx_t round_idx,
    output aes_block_u state,
    output logic       decrypt_q,
    output logic       last_round,
    output logic       busy,
    output logic       done,
    output aes_block_u block_out
);

    round_idx_t rnd_q;
    logic       start_ok;

    assign start_ok = start && !busy && key_ready;

    // idle: key for the initial whitening; busy: key of the round being applied
    always_comb begin
        if (busy) begin
            round_idx = decrypt_q ? round_idx_t'(NUM_ROUNDS) - rnd_q : rnd_q;
        end else begin
            round_idx = req.decrypt ? round_idx_t'(NUM_ROUNDS) : '0;
        end
    end

    assign last_round = busy && (rnd_q == round_idx_t'(NUM_ROUNDS));

    always_ff @(posedge clk) begin
        if (reset) begin
            busy      <= 1'b0;
            done      <= 1'b0;
            rnd_q     <= '0;
            decrypt_q <= 1'b0;
            block_out <= '0;
        end else begin
            done <= 1'b0;
            if (start_ok) begin
                busy      <= 1'b1;
                rnd_q     <= 4'd1;
                decrypt_q <= req.decrypt;
            end else if (busy) begin
                rnd_q <= rnd_q + 4'd1;
                if (last_round) begin
                    busy      <= 1'b0;
                    done      <= 1'b1;
                    block_out <= next_state;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start_ok) begin
            state.word <= req.data.word ^ round_key.word;
        end else if (busy) begin
            state <= next_state;
        end
    end

    a_done_idle: assert property (@(posedge clk) disable iff (reset) !(done && busy));

    // a block only starts on a fully expanded key
    a_start_key: assert property (@(posedge clk) disable iff (reset)
        $rose(busy) |-> $past(key_ready));

endmodule

//--- logic/aes_top.sv
`timescale 1ns/1ps

module aes_top
    import aes_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       key_load,
    input  aes_key_t   key,
    output logic       key_ready,
    input  logic       start,
    input  logic       decrypt,
    input  aes_block_u block_in,
    output logic       busy,
    output logic       done,
    output aes_block_u block_out
);

    aes_req_t   req;
    round_idx_t round_idx;
    aes_block_u round_key;
    aes_block_u state;
    aes_block_u next_state;
    logic       decrypt_q;
    logic       last_round;

    assign req.decrypt = decrypt;
    assign req.data    = block_in;

    aes_key_schedule i_key_schedule (
        .clk       (clk),
        .reset     (reset),
        .key_load  (key_load),
        .key       (key),
        .busy      (busy),
        .round_idx (round_idx),
        .round_key (round_key),
        .key_ready (key_ready)
    );

    aes_core i_core (
        .clk        (clk),
        .reset      (reset),
        .req        (req),
        .start      (start),
        .key_ready  (key_ready),
        .round_key  (round_key),
        .next_state (next_state),
        .round_idx  (round_idx),
        .state      (state),
        .decrypt_q  (decrypt_q),
        .last_round (last_round),
        .busy       (busy),
        .done       (done),
        .block_out  (block_out)
    );

    aes_round i_round (
        .state      (state),
        .round_key  (round_key),
        .decrypt    (decrypt_q),
        .last_round (last_round),
        .next_state (next_state)
    );

endmodule

//--- dv/aes_ref.svh
`ifndef AES_REF_SVH
`define AES_REF_SVH

// byte i of a block sits at bits 127-8*i, bytes run column by column

function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
    logic [7:0] p;
    logic [7:0] x;
    p = 8'h00;
    x = a;
    for (int i = 0; i < 8; i++) begin
        if (b[i]) begin
            p = p ^ x;
        end
        x = {x[6:0], 1'b0} ^ (x[7] ? 8'h1b : 8'h00);
    end
    return p;
endfunction

function automatic logic [127:0] byte_subst(input logic [127:0] s, input logic inv);
    for (int i = 0; i < 16; i++) begin
        s[127 - 8*i -: 8] = inv ? INV_SBOX[s[127 - 8*i -: 8]] : SBOX[s[127 - 8*i -: 8]];
    end
    return s;
endfunction

// row r moves left by r columns
function automatic logic [127:0] row_rotate(input logic [127:0] s, input logic inv);
    logic [127:0] o;
    int           src;
    int           dst;
    for (int c = 0; c < 4; c++) begin
        for (int r = 0; r < 4; r++) begin
            src = 4*((c + r) % 4) + r;
            dst = 4*c + r;
            if (inv) begin
                o[127 - 8*src -: 8] = s[127 - 8*dst -: 8];
            end else begin
                o[127 - 8*dst -: 8] = s[127 - 8*src -: 8];
            end
        end
    end
    return o;
endfunction

// circulant rows, {2,3,1,1} forward and {e,b,d,9} inverse
function automatic logic [127:0] column_mix(input logic [127:0] s, input logic inv);
    logic [7:0]   m [0:3];
    logic [7:0]   acc;
    logic [127:0] o;
    if (inv) begin
        m = '{8'h0e, 8'h0b, 8'h0d, 8'h09};
    end else begin
        m = '{8'h02, 8'h03, 8'h01, 8'h01};
    end
    for (int c = 0; c < 4; c++) begin
        for (int r = 0; r < 4; r++) begin
            acc = 8'h00;
            for (int k = 0; k < 4; k++) begin
                acc = acc ^ gf_mul(m[(k + 4 - r) % 4], s[127 - 8*(4*c + k) -: 8]);
            end
            o[127 - 8*(4*c + r) -: 8] = acc;
        end
    end
    return o;
endfunction

function automatic logic [127:0] round_key_of(input logic [127:0] key, input int r);
    logic [31:0] w [0:43];
    logic [31:0] t;
    logic [7:0]  rc;
    rc = 8'h01;
    for (int i = 0; i < 44; i++) begin
        if (i < 4) begin
            w[i] = key[127 - 32*i -: 32];
        end else begin
            t = w[i - 1];
            if (i % 4 == 0) begin
                // rotate, substitute, add the round constant
                t = {SBOX[t[23:16]], SBOX[t[15:8]], SBOX[t[7:0]], SBOX[t[31:24]]}
                    ^ {rc, 24'h000000};
                rc = gf_mul(rc, 8'h02);
            end
            w[i] = w[i - 4] ^ t;
        end
    end
    return {w[4*r], w[4*r + 1], w[4*r + 2], w[4*r + 3]};
endfunction

function automatic logic [127:0] aes_encrypt_ref(input logic [127:0] key,
                                                 input logic [127:0] pt);
    logic [127:0] s;
    s = pt ^ round_key_of(key, 0);
    for (int r = 1; r <= 10; r++) begin
        s = row_rotate(byte_subst(s, 1'b0), 1'b0);
        if (r < 10) begin
            s = column_mix(s, 1'b0);
        end
        s = s ^ round_key_of(key, r);
    end
    return s;
endfunction

function automatic logic [127:0] aes_decrypt_ref(input logic [127:0] key,
                                                 input logic [127:0] ct);
    logic [127:0] s;
    s = ct ^ round_key_of(key, 10);
    for (int r = 9; r >= 0; r--) begin
        s = byte_subst(row_rotate(s, 1'b1), 1'b1) ^ round_key_of(key, r);
        if (r > 0) begin
            s = column_mix(s, 1'b1);
        end
    end
    return s;
endfunction

`endif

//--- dv/aes_checker.sv
`timescale 1ns/1ps

module aes_checker
    import aes_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       key_load,
    input  aes_key_t   key,
    input  logic       key_ready,
    input  logic       start,
    input  logic       decrypt,
    input  aes_block_u block_in,
    input  logic       busy,
    input  logic       done,
    input  aes_block_u block_out,
    output int         errors,
    output int         checks
);

    `include "aes_ref.svh"

    // FIPS-197 appendix C.1
    localparam logic [127:0] KAT_KEY = 128'h000102030405060708090a0b0c0d0e0f;
    localparam logic [127:0] KAT_PT  = 128'h00112233445566778899aabbccddeeff;
    localparam logic [127:0] KAT_CT  = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;

    logic [127:0] exp_q [$];
    logic [127:0] in_q [$];
    logic         dec_q [$];
    int           start_q [$];
    logic [127:0] cur_key;
    logic [127:0] exp;
    logic [127:0] blk_in;
    logic         blk_dec;
    logic [127:0] last_pt;
    logic [127:0] last_ct;
    logic         trip_ok;
    int           cycle = 0;
    int           load_cycle = 0;
    int           start_cycle;
    int           err_cnt;
    int           chk_cnt;
    logic         reset_q;
    logic         ready_q;
    logic         busy_q;

    always @(posedge clk) begin
        cycle = cycle + 1;
        if (reset) begin
            err_cnt = 0;
            chk_cnt = 0;
            trip_ok = 1'b0;
        end else begin
            if (reset_q) begin
                chk_cnt++;
                if (busy || done || key_ready || block_out.word != '0) begin
                    $display("outputs are not idle after reset");
                    err_cnt++;
                end
            end
            if (start && !busy && key_ready) begin
                start_q.push_back(cycle);
                in_q.push_back(block_in.word);
                dec_q.push_back(decrypt);
                exp_q.push_back(decrypt ? aes_decrypt_ref(cur_key, block_in.word)
                                        : aes_encrypt_ref(cur_key, block_in.word));
            end
            // a load during busy leaves the key alone
            if (key_load && !busy) begin
                cur_key = key;
                load_cycle = cycle;
                trip_ok = 1'b0;
            end
            if (key_ready && !ready_q) begin
                chk_cnt++;
                if (cycle - 1 - load_cycle != NUM_ROUNDS) begin
                    $display("key_ready rose %0d cycles after key_load instead of %0d",
                             cycle - 1 - load_cycle, NUM_ROUNDS);
                    err_cnt++;
                end
            end
            if (done) begin
                chk_cnt++;
                if (busy || !busy_q) begin
                    $display("busy did not fall in the cycle that done rose");
                    err_cnt++;
                end
                if (exp_q.size() == 0) begin
                    $display("done pulsed without an accepted start");
                    err_cnt++;
                end else begin
                    exp = exp_q.pop_front();
                    blk_in = in_q.pop_front();
                    blk_dec = dec_q.pop_front();
                    start_cycle = start_q.pop_front();
                    if (block_out.word != exp) begin
                        $display("Error: block_out got %h, expected %h", block_out.word, exp);
                        err_cnt++;
                    end
                    if (!blk_dec && cur_key == KAT_KEY && blk_in == KAT_PT
                        && block_out.word != KAT_CT) begin
                        $display("Error: block_out got %h, expected %h",
                                 block_out.word, KAT_CT);
                        err_cnt++;
                    end
                    // decrypting the last ciphertext gives its plaintext back
                    if (blk_dec && trip_ok && blk_in == last_ct
                        && block_out.word != last_pt) begin
                        $display("Error: block_out got %h, expected %h",
                                 block_out.word, last_pt);
                        err_cnt++;
                    end
                    if (!blk_dec) begin
                        last_pt = blk_in;
                        last_ct = block_out.word;
                        trip_ok = 1'b1;
                    end
                    // done is set one edge before it is seen here
                    if (cycle - 1 - start_cycle != NUM_ROUNDS) begin
                        $display("done came %0d cycles after its start instead of %0d",
                                 cycle - 1 - start_cycle, NUM_ROUNDS);
                        err_cnt++;
                    end
                end
            end
        end
        reset_q <= reset;
        ready_q <= key_ready;
        busy_q  <= busy;
        errors  <= err_cnt;
        checks  <= chk_cnt;
    end

endmodule

//--- dv/aes_tb.sv
`timescale 1ns/1ps

module aes_tb
    import aes_pkg::*;
();

    localparam logic [127:0] KAT_KEY = 128'h000102030405060708090a0b0c0d0e0f;
    localparam logic [127:0] KAT_PT  = 128'h00112233445566778899aabbccddeeff;

    localparam int NUM_KEYS       = 4;
    localparam int BLOCKS_PER_KEY = 12;
    localparam int BLOCK_CYCLES   = 13;
    localparam int KEY_CYCLES     = 13;
    localparam int TEST_CYCLES    = NUM_KEYS * (KEY_CYCLES + 3 * BLOCKS_PER_KEY * BLOCK_CYCLES)
                                  + 8 * KEY_CYCLES + 10 * BLOCK_CYCLES + 40;
    localparam int WATCHDOG_NS    = (2 * TEST_CYCLES + 500) * 4;

    logic         clk = 1'b0;
    logic         reset;
    logic         key_load;
    aes_key_t     key;
    logic         key_ready;
    logic         start;
    logic         decrypt;
    aes_block_u   block_in;
    logic         busy;
    logic         done;
    aes_block_u   block_out;
    int           errors;
    int           checks;
    int           tb_fails;
    int           errors_at;
    int           checks_at;
    logic [31:0]  lcg_state;
    logic [127:0] blk;
    logic [127:0] ct;
    logic [127:0] res;

    always #2 clk = ~clk;

    aes_top i_dut (
        .clk       (clk),
        .reset     (reset),
        .key_load  (key_load),
        .key       (key),
        .key_ready (key_ready),
        .start     (start),
        .decrypt   (decrypt),
        .block_in  (block_in),
        .busy      (busy),
        .done      (done),
        .block_out (block_out)
    );

    aes_checker i_checker (
        .clk       (clk),
        .reset     (reset),
        .key_load  (key_load),
        .key       (key),
        .key_ready (key_ready),
        .start     (start),
        .decrypt   (decrypt),
        .block_in  (block_in),
        .busy      (busy),
        .done      (done),
        .block_out (block_out),
        .errors    (errors),
        .checks    (checks)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [127:0] rand_block();
        logic [127:0] b;
        for (int i = 0; i < 4; i++) begin
            lcg_state = lcg_next(lcg_state);
            b[32*i +: 32] = lcg_state;
        end
        return b;
    endfunction

    task automatic pulse_key_load(input logic [127:0] k);
        key_load <= 1'b1;
        key      <= k;
        @(posedge clk);
        key_load <= 1'b0;
    endtask

    task automatic wait_key_ready();
        int n;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!key_ready && n < 40);
        if (!key_ready) begin
            $display("key_ready never rose after a key load");
            tb_fails++;
        end
    endtask

    task automatic load_key(input logic [127:0] k);
        pulse_key_load(k);
        wait_key_ready();
    endtask

    task automatic pulse_start(input logic dec, input logic [127:0] b);
        start    <= 1'b1;
        decrypt  <= dec;
        block_in <= b;
        @(posedge clk);
        start    <= 1'b0;
    endtask

    task automatic wait_done(output logic [127:0] r);
        int n;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!done && n < 40);
        if (!done) begin
            $display("done never pulsed after a start");
            tb_fails++;
        end
        r = block_out.word;
    endtask

    task automatic run_block(input logic dec, input logic [127:0] b, output logic [127:0] r);
        pulse_start(dec, b);
        wait_done(r);
    endtask

    task automatic end_test(input string name);
        repeat (2) @(posedge clk);
        $display("test %s: %0d checks, %0d errors", name, checks - checks_at,
                 errors + tb_fails - errors_at);
        checks_at = checks;
        errors_at = errors + tb_fails;
    endtask

    initial begin
        reset     = 1'b1;
        key_load  = 1'b0;
        key       = '0;
        start     = 1'b0;
        decrypt   = 1'b0;
        block_in  = '0;
        lcg_state = 32'd84653;
        tb_fails  = 0;
        errors_at = 0;
        checks_at = 0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);

        // start with no key, then start while the key expands
        pulse_start(1'b0, rand_block());
        repeat (12) @(posedge clk);
        pulse_key_load(KAT_KEY);
        repeat (3) @(posedge clk);
        pulse_start(1'b0, rand_block());
        wait_key_ready();
        run_block(1'b0, rand_block(), res);
        end_test("reset and timing");

        run_block(1'b0, KAT_PT, ct);
        run_block(1'b1, ct, res);
        end_test("known vector");

        for (int k = 0; k < NUM_KEYS; k++) begin
            load_key(rand_block());
            for (int b = 0; b < BLOCKS_PER_KEY; b++) begin
                blk = rand_block();
                run_block(1'b0, blk, ct);
                run_block(1'b1, ct, res);
                run_block(1'b1, rand_block(), res);
            end
        end
        end_test("random round trip");

        // second start and a key load while busy
        pulse_start(1'b0, rand_block());
        repeat (3) @(posedge clk);
        pulse_start(1'b1, rand_block());
        pulse_key_load(rand_block());
        wait_done(res);
        repeat (12) @(posedge clk);
        blk = res;
        run_block(1'b0, blk, res);
        end_test("ignored strobes");

        blk = rand_block();
        load_key(rand_block());
        run_block(1'b0, blk, res);
        load_key(rand_block());
        run_block(1'b0, blk, ct);
        run_block(1'b1, ct, res);
        end_test("key reload");

        $display("total: %0d checks, %0d errors", checks, errors + tb_fails);
        if (errors == 0 && tb_fails == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout, the tests did not finish within %0d ns", WATCHDOG_NS);
        $display("Finished with errors");
        $finish;
    end

endmodule

//--- list.f
+incdir+dv
logic/aes_pkg.sv
logic/aes_key_schedule.sv
logic/aes_round.sv
logic/aes_core.sv
logic/aes_top.sv
dv/aes_checker.sv
dv/aes_tb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -sv
TOP      = aes_tb
FILELIST = list.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "Finished with no errors" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
